// ==== Makefile ====
# Verilator flow for the hs_ad_da loopback controller testbench

TOP := tb_hs_ad_da

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/ad_capture.sv ====
/* ADC capture and window statistics
   Samples ad_data and ad_otr at ad_clk rise and reports max, min and otr count per window */

`timescale 1ns/1ps

module ad_capture import hs_ad_da_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_sync_n,
  input  logic              ad_tick,    // ad_clk rises on the next edge
  input  logic [DATA_W-1:0] ad_data,
  input  logic              ad_otr,     // Input out of range
  output logic [DATA_W-1:0] win_max,
  output logic [DATA_W-1:0] win_min,
  output logic [CNT_W-1:0]  otr_cnt,
  output logic              win_valid   // One-cycle result strobe
);

  logic [DATA_W-1:0]    samp_data;
  logic                 samp_otr;
  logic                 samp_vld;      // Fresh sample in samp_data
  logic [WIN_CNT_W-1:0] win_cnt;       // Samples taken this window
  logic [DATA_W-1:0]    run_max;
  logic [DATA_W-1:0]    run_min;
  logic [CNT_W-1:0]     run_otr;
  logic                 first_samp;
  logic                 last_samp;
  logic [DATA_W-1:0]    nxt_max;
  logic [DATA_W-1:0]    nxt_min;
  logic [CNT_W-1:0]     nxt_otr;

  // ------------------------------------------------------------------
  // Sample register
  // ------------------------------------------------------------------
  always_ff @(posedge sys_clk) begin
    if (ad_tick) begin
      samp_data <= ad_data;   // Value at ad_clk rise
      samp_otr  <= ad_otr;
    end
  end

  // ------------------------------------------------------------------
  // Running statistics seeded by the first sample of a window
  // ------------------------------------------------------------------
  assign first_samp = (win_cnt == '0);
  assign last_samp  = (win_cnt == WIN_CNT_W'(WIN_LEN - 1));

  assign nxt_max = (first_samp || samp_data > run_max) ? samp_data : run_max;
  assign nxt_min = (first_samp || samp_data < run_min) ? samp_data : run_min;
  assign nxt_otr = first_samp ? CNT_W'(samp_otr) : run_otr + CNT_W'(samp_otr);

  always_ff @(posedge sys_clk) begin
    if (samp_vld) begin
      run_max <= nxt_max;
      run_min <= nxt_min;
      run_otr <= nxt_otr;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      samp_vld  <= 1'b0;
      win_cnt   <= '0;
      win_valid <= 1'b0;
      win_max   <= '0;
      win_min   <= '0;
      otr_cnt   <= '0;
    end else begin
      samp_vld  <= ad_tick;
      win_valid <= samp_vld && last_samp;  // Single pulse per window
      if (samp_vld) begin
        win_cnt <= last_samp ? '0 : win_cnt + WIN_CNT_W'(1);
      end
      if (samp_vld && last_samp) begin
        win_max <= nxt_max;       // Results held until next window
        win_min <= nxt_min;
        otr_cnt <= nxt_otr;
      end
    end
  end

endmodule

// ==== src/clk_div.sv ====
/* Converter clock divider
   Synchronizes the board reset and derives da_clk and ad_clk with one-cycle ticks */

`timescale 1ns/1ps

module clk_div import hs_ad_da_pkg::*; (
  input  logic sys_clk,
  input  logic arst_n,
  output logic rst_sync_n,   // Internal reset with async assert
  output logic da_clk,
  output logic da_tick,      // Cycle before da_clk falls
  output logic ad_clk,
  output logic ad_tick       // Cycle before ad_clk rises
);

  logic [1:0]          rst_pipe;   // Two-stage release
  logic [AD_DIV_W-1:0] div_cnt;    // Free-running divider

  // ------------------------------------------------------------------
  // Reset synchronizer
  // ------------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[0], 1'b1};  // Shift in release
    end
  end

  assign rst_sync_n = rst_pipe[1];

  // ------------------------------------------------------------------
  // Divider counter driving both converter clocks from its flops
  // ------------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + AD_DIV_W'(1);
    end
  end

  assign da_clk = div_cnt[DA_DIV_W-1];  // sys_clk / DA_DIV
  assign ad_clk = div_cnt[AD_DIV_W-1];  // sys_clk / AD_DIV

  // Low bits all ones so da_clk falls on the next edge
  assign da_tick = (div_cnt[DA_DIV_W-1:0] == DA_DIV_W'(DA_DIV - 1));
  // Half way through the ad_clk period so the rise follows
  assign ad_tick = (div_cnt == AD_DIV_W'(AD_DIV / 2 - 1));

endmodule

// ==== src/da_wave_send.sv ====
/* DAC waveform sender
   Phase accumulator with sine, triangle, sawtooth and square shaping onto da_data */

`timescale 1ns/1ps

module da_wave_send import hs_ad_da_pkg::*; (
  input  logic               sys_clk,
  input  logic               rst_sync_n,
  input  logic               da_tick,    // Update strobe, da_clk about to fall
  input  logic [PHASE_W-1:0] step,       // Phase increment per da_clk
  input  wave_sel_t          wave_sel,
  output logic [QADDR_W-1:0] rom_addr,
  input  logic [DATA_W-1:0]  rom_data,   // Quarter-wave magnitude
  output logic [DATA_W-1:0]  da_data
);

  logic [PHASE_W-1:0] phase;       // Current point in the period
  wave_sel_t          wave_q;      // Opcode taken at the last tick
  logic               half_hi;     // Second half of the period
  logic               quad_odd;    // Quarters 1 and 3 run backwards
  logic [PHASE_W-1:0] phase_x2;
  logic [DATA_W-1:0]  sine_code;
  logic [DATA_W-1:0]  tri_code;
  logic [DATA_W-1:0]  saw_code;
  logic [DATA_W-1:0]  sq_code;
  logic [DATA_W-1:0]  wave_code;   // Next DAC sample

  assign half_hi  = phase[PHASE_W-1];
  assign quad_odd = phase[PHASE_W-2];

  // Mirror the table address on the falling quarters
  assign rom_addr = quad_odd ? ~phase[QADDR_W-1:0] : phase[QADDR_W-1:0];

  // ------------------------------------------------------------------
  // Waveform shaping
  // ------------------------------------------------------------------
  // Offset sine around midscale
  assign sine_code = half_hi ? DATA_W'(MIDSCALE - 1) - rom_data
                             : DATA_W'(MIDSCALE) + rom_data;

  assign phase_x2 = {phase[PHASE_W-2:0], 1'b0};
  assign tri_code = half_hi ? DATA_W'(~phase_x2) : DATA_W'(phase_x2);  // 511 - 2p on way down
  assign saw_code = DATA_W'(phase);
  assign sq_code  = half_hi ? '0 : '1;   // Full scale high half

  always_comb begin
    case (wave_q)
      WAVE_SINE:   wave_code = sine_code;
      WAVE_TRI:    wave_code = tri_code;
      WAVE_SAW:    wave_code = saw_code;
      WAVE_SQUARE: wave_code = sq_code;
      default:     wave_code = DATA_W'(MIDSCALE);
    endcase
  end

  // ------------------------------------------------------------------
  // Tick update, sample out then advance phase and opcode
  // ------------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      phase   <= '0;
      wave_q  <= WAVE_SINE;        // Opcode of the first sample
      da_data <= DATA_W'(MIDSCALE);
    end else if (da_tick) begin
      da_data <= wave_code;        // Built from previous tick's phase
      phase   <= phase + step;     // Wraps at 256
      wave_q  <= wave_sel;
    end
  end

endmodule

// ==== src/hs_ad_da.sv ====
/* Mixed-signal loopback board top
   8-bit DAC waveform generator and 8-bit ADC window monitor on one sys_clk domain */

`timescale 1ns/1ps

module hs_ad_da import hs_ad_da_pkg::*; (
  input  logic               sys_clk,
  input  logic               arst_n,      // Board reset
  // DAC side
  input  wave_sel_t          wave_sel,
  input  logic [PHASE_W-1:0] step,
  output logic               da_clk,
  output logic [DATA_W-1:0]  da_data,
  // ADC side
  input  logic [DATA_W-1:0]  ad_data,
  input  logic               ad_otr,
  output logic               ad_clk,
  output logic [DATA_W-1:0]  win_max,
  output logic [DATA_W-1:0]  win_min,
  output logic [CNT_W-1:0]   otr_cnt,
  output logic               win_valid
);

  logic               rst_sync_n;
  logic               da_tick;
  logic               ad_tick;
  logic [QADDR_W-1:0] rom_addr;   // Sender to table
  logic [DATA_W-1:0]  rom_data;   // Table to sender

  // Reset release and converter clocks
  clk_div u_clk_div (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .rst_sync_n (rst_sync_n),
    .da_clk     (da_clk),
    .da_tick    (da_tick),
    .ad_clk     (ad_clk),
    .ad_tick    (ad_tick)
  );

  // ------------------------------------------------------------------
  // DAC path
  // ------------------------------------------------------------------
  da_wave_send u_da_wave_send (
    .sys_clk    (sys_clk),
    .rst_sync_n (rst_sync_n),
    .da_tick    (da_tick),
    .step       (step),
    .wave_sel   (wave_sel),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .da_data    (da_data)
  );

  sine_rom_q64 u_sine_rom_q64 (
    .sys_clk    (sys_clk),
    .rst_sync_n (rst_sync_n),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data)
  );

  // ADC path
  ad_capture u_ad_capture (
    .sys_clk    (sys_clk),
    .rst_sync_n (rst_sync_n),
    .ad_tick    (ad_tick),
    .ad_data    (ad_data),
    .ad_otr     (ad_otr),
    .win_max    (win_max),
    .win_min    (win_min),
    .otr_cnt    (otr_cnt),
    .win_valid  (win_valid)
  );

endmodule

// ==== src/hs_ad_da_pkg.sv ====
/* hs_ad_da shared definitions
   Sample and phase widths, clock divider ratios, ADC window size, waveform opcodes */

package hs_ad_da_pkg;

  // ------------------------------------------------------------------
  // Data path widths
  // ------------------------------------------------------------------
  localparam int DATA_W   = 8;    // DAC and ADC sample width
  localparam int PHASE_W  = 8;    // 256 points per period
  localparam int QADDR_W  = 6;    // Quarter-wave table index

  // ------------------------------------------------------------------
  // Clock divider, sys_clk cycles per converter clock
  // ------------------------------------------------------------------
  localparam int DA_DIV    = 2;
  localparam int AD_DIV    = 4;
  localparam int DA_DIV_W  = $clog2(DA_DIV);  // Bits of divider feeding da_clk
  localparam int AD_DIV_W  = $clog2(AD_DIV);  // Full divider counter width

  // ADC statistics window
  localparam int WIN_LEN   = 64;               // Samples per window
  localparam int WIN_CNT_W = $clog2(WIN_LEN);
  localparam int CNT_W     = 7;                // Otr count, 0 to WIN_LEN

  localparam int MIDSCALE  = 128;              // DAC code while idle

  // Waveform opcode
  typedef enum logic [1:0] {
    WAVE_SINE   = 2'd0,
    WAVE_TRI    = 2'd1,
    WAVE_SAW    = 2'd2,
    WAVE_SQUARE = 2'd3
  } wave_sel_t;

endpackage

// ==== src/sine_rom_q64.sv ====
/* Quarter-wave sine table
   64 magnitudes of 127*sin(2*pi*(k+0.5)/256), registered output */

`timescale 1ns/1ps

module sine_rom_q64 import hs_ad_da_pkg::*; (
  input  logic               sys_clk,
  input  logic               rst_sync_n,
  input  logic [QADDR_W-1:0] rom_addr,
  output logic [DATA_W-1:0]  rom_data   // One cycle after rom_addr
);

  always_ff @(posedge sys_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      rom_data <= '0;
    end else begin
      case (rom_addr)
        6'd0:  rom_data <= 8'd2;    // Half step past zero
        6'd1:  rom_data <= 8'd5;
        6'd2:  rom_data <= 8'd8;
        6'd3:  rom_data <= 8'd11;
        6'd4:  rom_data <= 8'd14;
        6'd5:  rom_data <= 8'd17;
        6'd6:  rom_data <= 8'd20;
        6'd7:  rom_data <= 8'd23;
        6'd8:  rom_data <= 8'd26;
        6'd9:  rom_data <= 8'd29;
        6'd10: rom_data <= 8'd32;
        6'd11: rom_data <= 8'd35;
        6'd12: rom_data <= 8'd38;
        6'd13: rom_data <= 8'd41;
        6'd14: rom_data <= 8'd44;
        6'd15: rom_data <= 8'd47;
        6'd16: rom_data <= 8'd50;
        6'd17: rom_data <= 8'd53;
        6'd18: rom_data <= 8'd56;
        6'd19: rom_data <= 8'd58;
        6'd20: rom_data <= 8'd61;
        6'd21: rom_data <= 8'd64;   // Near 30 degrees
        6'd22: rom_data <= 8'd67;
        6'd23: rom_data <= 8'd69;
        6'd24: rom_data <= 8'd72;
        6'd25: rom_data <= 8'd74;
        6'd26: rom_data <= 8'd77;
        6'd27: rom_data <= 8'd79;
        6'd28: rom_data <= 8'd82;
        6'd29: rom_data <= 8'd84;
        6'd30: rom_data <= 8'd86;
        6'd31: rom_data <= 8'd89;
        6'd32: rom_data <= 8'd91;   // Past 45 degrees
        6'd33: rom_data <= 8'd93;
        6'd34: rom_data <= 8'd95;
        6'd35: rom_data <= 8'd97;
        6'd36: rom_data <= 8'd99;
        6'd37: rom_data <= 8'd101;
        6'd38: rom_data <= 8'd103;
        6'd39: rom_data <= 8'd105;
        6'd40: rom_data <= 8'd106;
        6'd41: rom_data <= 8'd108;
        6'd42: rom_data <= 8'd110;
        6'd43: rom_data <= 8'd111;
        6'd44: rom_data <= 8'd113;
        6'd45: rom_data <= 8'd114;
        6'd46: rom_data <= 8'd115;
        6'd47: rom_data <= 8'd117;
        6'd48: rom_data <= 8'd118;
        6'd49: rom_data <= 8'd119;
        6'd50: rom_data <= 8'd120;
        6'd51: rom_data <= 8'd121;
        6'd52: rom_data <= 8'd122;
        6'd53: rom_data <= 8'd123;
        6'd54: rom_data <= 8'd124;
        6'd55: rom_data <= 8'd124;
        6'd56: rom_data <= 8'd125;
        6'd57: rom_data <= 8'd125;
        6'd58: rom_data <= 8'd126;
        6'd59: rom_data <= 8'd126;
        6'd60: rom_data <= 8'd127;  // Flat top of the quarter
        6'd61: rom_data <= 8'd127;
        6'd62: rom_data <= 8'd127;
        6'd63: rom_data <= 8'd127;
      endcase
    end
  end

endmodule

// ==== tb/hs_ad_da_asserts.sv ====
/* hs_ad_da protocol assertions
   Converter clock cadence, DAC update timing and window result limits */

`timescale 1ns/1ps

module hs_ad_da_asserts import hs_ad_da_pkg::*; (
  input logic              sys_clk,
  input logic              arst_n,
  input logic              da_clk,
  input logic [DATA_W-1:0] da_data,
  input logic              ad_clk,
  input logic              win_valid,
  input logic [CNT_W-1:0]  otr_cnt
);

  // ------------------------------------------------------------------
  // Result strobe and count range
  // ------------------------------------------------------------------
  a_valid_one_cycle: assert property (@(posedge sys_clk) disable iff (!arst_n)
    win_valid |=> !win_valid)
    else $error("win_valid high for two cycles in a row");

  a_otr_range: assert property (@(posedge sys_clk) disable iff (!arst_n)
    otr_cnt <= CNT_W'(WIN_LEN))
    else $error("otr_cnt above window length");

  // DAC code moves only together with a da_clk fall
  a_da_update: assert property (@(posedge sys_clk) disable iff (!arst_n)
    (da_data != $past(da_data)) |-> (!da_clk && $past(da_clk)))
    else $error("da_data changed away from a da_clk falling edge");

  // ad_clk is sys_clk / 4, so no two toggles back to back
  a_ad_cadence: assert property (@(posedge sys_clk) disable iff (!arst_n)
    (ad_clk != $past(ad_clk)) |=> (ad_clk == $past(ad_clk)))
    else $error("ad_clk toggled on consecutive sys_clk cycles");

endmodule

bind hs_ad_da hs_ad_da_asserts i_hs_ad_da_asserts (
  .sys_clk   (sys_clk),
  .arst_n    (arst_n),
  .da_clk    (da_clk),
  .da_data   (da_data),
  .ad_clk    (ad_clk),
  .win_valid (win_valid),
  .otr_cnt   (otr_cnt)
);

// ==== tb/tb_hs_ad_da.sv ====
/* hs_ad_da testbench
   LCG-driven DAC waveform and ADC window stimulus checked against reference models */

`timescale 1ns/1ps

module tb_hs_ad_da import hs_ad_da_pkg::*; ;

  localparam int TIMEOUT_PAD = 200;   // Slack cycles on every wait

  logic               sys_clk;
  logic               arst_n;
  wave_sel_t          wave_sel;
  logic [PHASE_W-1:0] step;
  logic               da_clk;
  logic [DATA_W-1:0]  da_data;
  logic [DATA_W-1:0]  ad_data;
  logic               ad_otr;
  logic               ad_clk;
  logic [DATA_W-1:0]  win_max;
  logic [DATA_W-1:0]  win_min;
  logic [CNT_W-1:0]   otr_cnt;
  logic               win_valid;

  int unsigned        lcg_state;
  int                 err_cnt;
  int                 chk_cnt;
  int                 to_cnt;
  string              test_name;
  int                 otr_mode;      // 0 sparse, 1 never, 2 always
  bit                 live_mode;     // Random opcode and step changes
  // DAC model
  logic               da_prev;
  logic [PHASE_W-1:0] m_phase;
  wave_sel_t          m_sel;
  logic [DATA_W-1:0]  exp_da;        // Code due at next da_clk rise
  int                 da_rises;
  // ADC window model
  logic               ad_prev;
  logic [DATA_W-1:0]  m_max;
  logic [DATA_W-1:0]  m_min;
  int                 m_otr;
  int                 m_samples;
  int                 win_seen;
  logic [DATA_W-1:0]  exp_max_q[$];
  logic [DATA_W-1:0]  exp_min_q[$];
  int                 exp_otr_q[$];

  hs_ad_da i_hs_ad_da (.*);

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;   // 40 ns period
  end

  // ------------------------------------------------------------------
  // Random source and reference waveform
  // ------------------------------------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;           // Upper half of the state
  endfunction

  function automatic logic [DATA_W-1:0] ref_wave(logic [PHASE_W-1:0] p, wave_sel_t sel);
    int                pv = int'(p);
    int                q;
    int                k;
    int                mag;
    logic [DATA_W-1:0] code;
    q = pv % 64;
    k = ((pv / 64) % 2 == 1) ? 63 - q : q;   // Falling quarters mirrored
    mag = $rtoi(127.0 * $sin(2.0 * 3.141592653589793 * (real'(k) + 0.5) / 256.0) + 0.5);
    case (sel)
      WAVE_SINE: code = (pv < 128) ? DATA_W'(128 + mag) : DATA_W'(127 - mag);
      WAVE_TRI:  code = (pv < 128) ? DATA_W'(2 * pv) : DATA_W'(511 - 2 * pv);
      WAVE_SAW:  code = DATA_W'(pv);
      default:   code = (pv < 128) ? DATA_W'(255) : DATA_W'(0);
    endcase
    return code;
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic check_da(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_stat(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_cnt(string name, logic [CNT_W-1:0] exp, logic [CNT_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  // ------------------------------------------------------------------
  // Monitor run on each falling edge before new inputs are driven
  // ------------------------------------------------------------------
  task automatic observe();
    if (da_clk && !da_prev) begin
      check_da({test_name, " da_data"}, exp_da, da_data);
      da_rises++;
    end
    if (!da_clk && da_prev) begin      // Tick edge where step and wave_sel were taken
      exp_da  = ref_wave(m_phase, m_sel);
      m_phase = m_phase + step;
      m_sel   = wave_sel;
    end
    da_prev = da_clk;
    if (ad_clk && !ad_prev) begin      // Sample at ad_clk rise
      if (m_samples == 0 || ad_data > m_max) m_max = ad_data;
      if (m_samples == 0 || ad_data < m_min) m_min = ad_data;
      m_otr = (m_samples == 0) ? int'(ad_otr) : m_otr + int'(ad_otr);
      m_samples++;
      if (m_samples == WIN_LEN) begin
        exp_max_q.push_back(m_max);
        exp_min_q.push_back(m_min);
        exp_otr_q.push_back(m_otr);
        m_samples = 0;
      end
    end
    ad_prev = ad_clk;
    if (win_valid) begin
      if (exp_max_q.size() == 0) begin
        err_cnt++;
        $display("ERROR: win_valid pulsed but the model has no finished window");
      end else begin
        check_stat({test_name, " win_max"}, exp_max_q.pop_front(), win_max);
        check_stat({test_name, " win_min"}, exp_min_q.pop_front(), win_min);
        check_cnt({test_name, " otr_cnt"}, CNT_W'(exp_otr_q.pop_front()), otr_cnt);
        win_seen++;
      end
    end
  endtask

  // One sys_clk cycle of observing and then driving on the falling edge
  task automatic advance();
    @(negedge sys_clk);
    observe();
    ad_data = DATA_W'(lcg_next());
    case (otr_mode)
      1:       ad_otr = 1'b0;
      2:       ad_otr = 1'b1;
      default: ad_otr = (lcg_next() % 16 == 0);   // Sparse overrange
    endcase
    if (live_mode) begin
      if (lcg_next() % 16 == 0) wave_sel = wave_sel_t'(lcg_next() % 4);
      if (lcg_next() % 16 == 0) step = PHASE_W'(lcg_next());
    end
  endtask

  task automatic run_da_periods(int n);
    int target;
    int cycles;
    target = da_rises + n;
    cycles = 0;
    while (da_rises < target && cycles < n * DA_DIV + TIMEOUT_PAD) begin
      advance();
      cycles++;
    end
    if (da_rises < target) begin
      to_cnt++;
      $display("ERROR: %s timed out waiting for %0d da_clk periods", test_name, n);
    end
  endtask

  task automatic wait_windows(int n);
    int target;
    int cycles;
    target = win_seen + n;
    cycles = 0;
    while (win_seen < target && cycles < (n + 1) * WIN_LEN * AD_DIV + TIMEOUT_PAD) begin
      advance();
      cycles++;
    end
    if (win_seen < target) begin
      to_cnt++;
      $display("ERROR: %s timed out waiting for %0d win_valid pulses", test_name, n);
    end
  endtask

  // Level checks while the converter side is held in reset
  task automatic check_idle();
    check_bit({test_name, " da_clk"}, 1'b0, da_clk);
    check_bit({test_name, " ad_clk"}, 1'b0, ad_clk);
    check_bit({test_name, " win_valid"}, 1'b0, win_valid);
    check_da({test_name, " da_data"}, DATA_W'(MIDSCALE), da_data);
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    lcg_state = 32'd23480;
    err_cnt = 0;
    chk_cnt = 0;
    to_cnt = 0;
    da_rises = 0;
    win_seen = 0;
    da_prev = 1'b0;
    ad_prev = 1'b0;
    m_phase = '0;
    m_sel = WAVE_SINE;                 // Opcode held by the sender in reset
    exp_da = DATA_W'(MIDSCALE);
    m_max = '0;
    m_min = '0;
    m_otr = 0;
    m_samples = 0;
    otr_mode = 0;
    live_mode = 1'b0;
    arst_n = 1'b0;
    wave_sel = WAVE_SINE;
    step = '0;
    ad_data = '0;
    ad_otr = 1'b0;

    test_name = "reset";
    for (int i = 0; i < 8; i++) begin
      advance();
      if (i >= 2) check_idle();
    end
    arst_n = 1'b1;
    advance();
    check_idle();                      // Synchronizer still holding

    test_name = "saw_square";
    step = PHASE_W'(lcg_next());
    wave_sel = WAVE_SAW;
    run_da_periods(300);
    wave_sel = WAVE_SQUARE;
    run_da_periods(300);

    test_name = "sine_tri_step1";
    step = PHASE_W'(1);
    wave_sel = WAVE_SINE;
    run_da_periods(260);
    wave_sel = WAVE_TRI;
    run_da_periods(260);
    test_name = "sine_tri_odd";
    step = PHASE_W'(lcg_next()) | PHASE_W'(1);   // Odd step hits every phase
    wave_sel = WAVE_SINE;
    run_da_periods(260);
    wave_sel = WAVE_TRI;
    run_da_periods(260);

    test_name = "live_changes";
    live_mode = 1'b1;
    run_da_periods(600);
    live_mode = 1'b0;

    // Second window after a mode change holds only new samples
    test_name = "adc_in_range";
    otr_mode = 1;
    wait_windows(2);
    check_cnt("adc_in_range full window", '0, otr_cnt);
    test_name = "adc_otr_high";
    otr_mode = 2;
    wait_windows(2);
    check_cnt("adc_otr_high full window", CNT_W'(WIN_LEN), otr_cnt);
    test_name = "adc_sparse";
    otr_mode = 0;
    wait_windows(4);

    $display("Checks %0d, errors %0d, timeouts %0d, windows %0d",
             chk_cnt, err_cnt, to_cnt, win_seen);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/hs_ad_da_pkg.sv
src/clk_div.sv
src/sine_rom_q64.sv
src/da_wave_send.sv
src/ad_capture.sv
src/hs_ad_da.sv
tb/hs_ad_da_asserts.sv
tb/tb_hs_ad_da.sv
